// File: logic/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // core size.
    localparam int num_threads = 4;
    localparam int num_warps   = 4;
    localparam int num_regs    = 32;
    localparam int nw_bits     = 2;
    localparam int nr_bits     = 5;
    localparam int xlen        = 32;
    localparam int fflags_bits = 5;
    localparam int cnt_bits    = 32;

    // one completed instruction from an execution unit.
    typedef struct packed {
        logic                                valid;
        logic [nw_bits-1:0]                  wid;
        logic [31:0]                         pc;
        logic [num_threads-1:0]              tmask;
        logic                                wb;    // writes rd.
        logic [nr_bits-1:0]                  rd;
        logic [num_threads-1:0][xlen-1:0]    data;
    } commit_t;

    // fpu result carries its exception flags along.
    typedef struct packed {
        commit_t                             cmt;
        logic [fflags_bits-1:0]              fflags;
    } fpu_commit_t;

    // registered writeback record.
    typedef struct packed {
        logic                                valid;
        logic [nw_bits-1:0]                  wid;
        logic [31:0]                         pc;
        logic [num_threads-1:0]              tmask;
        logic [nr_bits-1:0]                  rd;
        logic [num_threads-1:0][xlen-1:0]    data;
    } wb_rec_t;

endpackage

`default_nettype wire

// File: logic/writeback_stage.sv
`timescale 1ns/10ps
`default_nettype none

module writeback_stage
    import wb_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire commit_t     alu_commit,
    input  wire commit_t     lsu_commit,
    input  wire commit_t     csr_commit,
    input  wire commit_t     mul_commit,
    input  wire fpu_commit_t fpu_commit,
    input  wire commit_t     gpu_commit,
    output logic             alu_ready,
    output logic             lsu_ready,
    output logic             csr_ready,
    output logic             mul_ready,
    output logic             fpu_ready,
    output logic             gpu_ready,
    output wb_rec_t          wb_rec,
    output logic [5:0]       accept
);

    logic    alu_wb;
    logic    lsu_wb;
    logic    csr_wb;
    logic    mul_wb;
    logic    fpu_wb;
    wb_rec_t sel_rec;

    function automatic wb_rec_t to_rec(commit_t c);
        wb_rec_t r;
        r.valid = c.valid;
        r.wid   = c.wid;
        r.pc    = c.pc;
        r.tmask = c.tmask;
        r.rd    = c.rd;
        r.data  = c.data;
        return r;
    endfunction

    // register-writing requests, gpu never writes.
    assign alu_wb = alu_commit.valid && alu_commit.wb;
    assign lsu_wb = lsu_commit.valid && lsu_commit.wb;
    assign csr_wb = csr_commit.valid && csr_commit.wb;
    assign mul_wb = mul_commit.valid && mul_commit.wb;
    assign fpu_wb = fpu_commit.cmt.valid && fpu_commit.cmt.wb;

    assign alu_ready = 1'b1;
    assign lsu_ready = !alu_wb;
    assign csr_ready = !alu_wb && !lsu_wb;
    assign mul_ready = !alu_wb && !lsu_wb && !csr_wb;
    assign fpu_ready = !alu_wb && !lsu_wb && !csr_wb && !mul_wb;
    assign gpu_ready = 1'b1;

    assign accept[0] = alu_commit.valid && alu_ready;
    assign accept[1] = lsu_commit.valid && lsu_ready;
    assign accept[2] = csr_commit.valid && csr_ready;
    assign accept[3] = mul_commit.valid && mul_ready;
    assign accept[4] = fpu_commit.cmt.valid && fpu_ready;
    assign accept[5] = gpu_commit.valid && gpu_ready;

    // fixed priority, alu first.
    always_comb begin
        sel_rec = '0;
        if (alu_wb) begin
            sel_rec = to_rec(alu_commit);
        end else if (lsu_wb) begin
            sel_rec = to_rec(lsu_commit);
        end else if (csr_wb) begin
            sel_rec = to_rec(csr_commit);
        end else if (mul_wb) begin
            sel_rec = to_rec(mul_commit);
        end else if (fpu_wb) begin
            sel_rec = to_rec(fpu_commit.cmt);
        end
    end

    always_ff @(posedge clk) begin
        wb_rec <= sel_rec;
        if (rst) begin
            wb_rec.valid <= 1'b0;
        end
    end

    // ready chain must leave a single writer per cycle.
    assert property (@(posedge clk) disable iff (rst)
        $onehot0(accept[4:0] & {fpu_commit.cmt.wb, mul_commit.wb, csr_commit.wb,
                                lsu_commit.wb, alu_commit.wb}))
        else $error("more than one register write accepted");

endmodule

`default_nettype wire

// File: logic/gpr_file.sv
`timescale 1ns/10ps
`default_nettype none

module gpr_file
    import wb_pkg::*;
(
    input  wire                              clk,
    input  wire                              rst,
    input  wire wb_rec_t                     wb_rec,
    input  wire                              rd_en,
    input  wire [nw_bits-1:0]                rd_wid,
    input  wire [nr_bits-1:0]                rd_reg,
    output logic [num_threads-1:0][xlen-1:0] rd_data
);

    logic [xlen-1:0] regs [num_warps][num_regs][num_threads];

    // lane writes under the thread mask.
    always_ff @(posedge clk) begin
        if (wb_rec.valid && wb_rec.rd != '0) begin
            for (int t = 0; t < num_threads; t++) begin
                if (wb_rec.tmask[t]) begin
                    regs[wb_rec.wid][wb_rec.rd][t] <= wb_rec.data[t];
                end
            end
        end
    end

    // r0 is hardwired zero.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int t = 0; t < num_threads; t++) begin
                if (rd_reg == '0) begin
                    rd_data[t] <= '0;
                end else begin
                    rd_data[t] <= regs[rd_wid][rd_reg][t]; // old value on collision.
                end
            end
        end
    end

    // an empty mask would mean a commit with no active lane got through.
    assert property (@(posedge clk) disable iff (rst)
        wb_rec.valid |-> (wb_rec.tmask != '0))
        else $error("writeback record with empty thread mask");

endmodule

`default_nettype wire

// File: logic/fflags_accum.sv
`timescale 1ns/10ps
`default_nettype none

module fflags_accum
    import wb_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire fpu_commit_t       fpu_commit,
    input  wire                    fpu_ready,
    input  wire                    flags_clr,
    input  wire [nw_bits-1:0]      flags_wid,
    output logic [fflags_bits-1:0] flags
);

    logic [fflags_bits-1:0] flags_q [num_warps];
    logic                   fpu_fire;

    // flags count even when no register is written.
    assign fpu_fire = fpu_commit.cmt.valid && fpu_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < num_warps; w++) begin
                flags_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < num_warps; w++) begin
                logic [fflags_bits-1:0] nxt;
                nxt = flags_q[w];
                if (flags_clr && flags_wid == nw_bits'(w)) begin
                    nxt = '0;
                end
                if (fpu_fire && fpu_commit.cmt.wid == nw_bits'(w)) begin
                    nxt = nxt | fpu_commit.fflags; // new flags survive a clear.
                end
                flags_q[w] <= nxt;
            end
        end
    end

    assign flags = flags_q[flags_wid];

endmodule

`default_nettype wire

// File: logic/retire_counter.sv
`timescale 1ns/10ps
`default_nettype none

module retire_counter
    import wb_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire [5:0]           accept,
    input  wire [nw_bits-1:0]   alu_wid,
    input  wire [nw_bits-1:0]   lsu_wid,
    input  wire [nw_bits-1:0]   csr_wid,
    input  wire [nw_bits-1:0]   mul_wid,
    input  wire [nw_bits-1:0]   fpu_wid,
    input  wire [nw_bits-1:0]   gpu_wid,
    input  wire [nw_bits-1:0]   cnt_wid,
    output logic [cnt_bits-1:0] count
);

    logic [5:0][nw_bits-1:0] wids;
    logic [2:0]              incr     [num_warps];
    logic [cnt_bits:0]       next_ext [num_warps];
    logic [cnt_bits-1:0]     count_q  [num_warps];

    assign wids = {gpu_wid, fpu_wid, mul_wid, csr_wid, lsu_wid, alu_wid};

    // up to six retirements per warp per cycle.
    always_comb begin
        for (int w = 0; w < num_warps; w++) begin
            incr[w] = '0;
            for (int s = 0; s < 6; s++) begin
                if (accept[s] && wids[s] == nw_bits'(w)) begin
                    incr[w] = incr[w] + 3'd1;
                end
            end
            next_ext[w] = {1'b0, count_q[w]} + (cnt_bits + 1)'(incr[w]);
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_warps; w++) begin
            if (rst) begin
                count_q[w] <= '0;
            end else begin
                count_q[w] <= next_ext[w][cnt_bits-1:0];
            end
        end
    end

    assign count = count_q[cnt_wid];

    for (genvar w = 0; w < num_warps; w++) begin : g_wrap_chk
        assert property (@(posedge clk) disable iff (rst) !next_ext[w][cnt_bits])
            else $error("retire counter of warp %0d wraps", w);
    end

endmodule

`default_nettype wire

// File: logic/writeback_top.sv
`timescale 1ns/10ps
`default_nettype none

module writeback_top
    import wb_pkg::*;
(
    input  wire                              clk,
    input  wire                              rst,
    input  wire commit_t                     alu_commit,
    input  wire commit_t                     lsu_commit,
    input  wire commit_t                     csr_commit,
    input  wire commit_t                     mul_commit,
    input  wire fpu_commit_t                 fpu_commit,
    input  wire commit_t                     gpu_commit,
    input  wire                              rd_en,
    input  wire [nw_bits-1:0]                rd_wid,
    input  wire [nr_bits-1:0]                rd_reg,
    input  wire                              flags_clr,
    input  wire [nw_bits-1:0]                flags_wid,
    input  wire [nw_bits-1:0]                cnt_wid,
    output logic                             alu_ready,
    output logic                             lsu_ready,
    output logic                             csr_ready,
    output logic                             mul_ready,
    output logic                             fpu_ready,
    output logic                             gpu_ready,
    output wb_rec_t                          wb_out,
    output logic [num_threads-1:0][xlen-1:0] rd_data,
    output logic [fflags_bits-1:0]           flags,
    output logic [cnt_bits-1:0]              count
);

    logic [5:0] accept;

    writeback_stage writeback_stage_i (
        .clk        (clk),
        .rst        (rst),
        .alu_commit (alu_commit),
        .lsu_commit (lsu_commit),
        .csr_commit (csr_commit),
        .mul_commit (mul_commit),
        .fpu_commit (fpu_commit),
        .gpu_commit (gpu_commit),
        .alu_ready  (alu_ready),
        .lsu_ready  (lsu_ready),
        .csr_ready  (csr_ready),
        .mul_ready  (mul_ready),
        .fpu_ready  (fpu_ready),
        .gpu_ready  (gpu_ready),
        .wb_rec     (wb_out),
        .accept     (accept)
    );

    gpr_file gpr_file_i (
        .clk     (clk),
        .rst     (rst),
        .wb_rec  (wb_out),
        .rd_en   (rd_en),
        .rd_wid  (rd_wid),
        .rd_reg  (rd_reg),
        .rd_data (rd_data)
    );

    fflags_accum fflags_accum_i (
        .clk        (clk),
        .rst        (rst),
        .fpu_commit (fpu_commit),
        .fpu_ready  (fpu_ready),
        .flags_clr  (flags_clr),
        .flags_wid  (flags_wid),
        .flags      (flags)
    );

    // warp ids come straight from the commit ports.
    retire_counter retire_counter_i (
        .clk     (clk),
        .rst     (rst),
        .accept  (accept),
        .alu_wid (alu_commit.wid),
        .lsu_wid (lsu_commit.wid),
        .csr_wid (csr_commit.wid),
        .mul_wid (mul_commit.wid),
        .fpu_wid (fpu_commit.cmt.wid),
        .gpu_wid (gpu_commit.wid),
        .cnt_wid (cnt_wid),
        .count   (count)
    );

endmodule

`default_nettype wire

// File: test/tb_writeback.sv
`timescale 1ns/10ps
`default_nettype none

module tb_writeback
    import wb_pkg::*;
();

    localparam int rand_cycles  = 800;
    localparam int init_cycles  = num_warps * (num_regs - 1);
    localparam int read_cycles  = num_warps * num_regs;
    localparam int total_cycles = 4 + init_cycles + rand_cycles + 3 + read_cycles
                                  + num_warps + 200;

    logic                             clk;
    logic                             rst;
    commit_t                          src [6]; // alu lsu csr mul fpu gpu.
    logic [fflags_bits-1:0]           fpu_ff;
    fpu_commit_t                      fpu_c;
    logic                             rd_en;
    logic [nw_bits-1:0]               rd_wid;
    logic [nr_bits-1:0]               rd_reg;
    logic                             flags_clr;
    logic [nw_bits-1:0]               flags_wid;
    logic [nw_bits-1:0]               cnt_wid;
    logic                             alu_ready;
    logic                             lsu_ready;
    logic                             csr_ready;
    logic                             mul_ready;
    logic                             fpu_ready;
    logic                             gpu_ready;
    wb_rec_t                          wb_out;
    logic [num_threads-1:0][xlen-1:0] rd_data;
    logic [fflags_bits-1:0]           flags;
    logic [cnt_bits-1:0]              count;

    // reference state.
    logic [num_threads-1:0][xlen-1:0] regs_m  [num_warps][num_regs];
    logic [fflags_bits-1:0]           flags_m [num_warps];
    logic [cnt_bits-1:0]              cnt_m   [num_warps];
    wb_rec_t                          exp_wb;
    logic [5:0]                       acc_q;

    integer seed = 32'hd2430c73;
    int     ready_errs = 0;
    int     wb_errs    = 0;
    int     rd_errs    = 0;
    int     flags_errs = 0;
    int     count_errs = 0;

    assign fpu_c.cmt    = src[4];
    assign fpu_c.fflags = fpu_ff;

    writeback_top writeback_top_i (
        .clk        (clk),
        .rst        (rst),
        .alu_commit (src[0]),
        .lsu_commit (src[1]),
        .csr_commit (src[2]),
        .mul_commit (src[3]),
        .fpu_commit (fpu_c),
        .gpu_commit (src[5]),
        .rd_en      (rd_en),
        .rd_wid     (rd_wid),
        .rd_reg     (rd_reg),
        .flags_clr  (flags_clr),
        .flags_wid  (flags_wid),
        .cnt_wid    (cnt_wid),
        .alu_ready  (alu_ready),
        .lsu_ready  (lsu_ready),
        .csr_ready  (csr_ready),
        .mul_ready  (mul_ready),
        .fpu_ready  (fpu_ready),
        .gpu_ready  (gpu_ready),
        .wb_out     (wb_out),
        .rd_data    (rd_data),
        .flags      (flags),
        .count      (count)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s ready %b, expected %b", $time, name, got, exp);
            ready_errs++;
        end
    endtask

    task automatic check_wb(input wb_rec_t got, input wb_rec_t exp);
        if (got.valid !== exp.valid) begin
            $display("ERR %0t: wb_out valid %b, expected %b", $time, got.valid, exp.valid);
            wb_errs++;
        end else if (exp.valid && got !== exp) begin
            $display("ERR %0t: wb_out wid %0d rd %0d pc %h, expected wid %0d rd %0d pc %h",
                     $time, got.wid, got.rd, got.pc, exp.wid, exp.rd, exp.pc);
            wb_errs++;
        end
    endtask

    task automatic check_rd(input logic [num_threads-1:0][xlen-1:0] got,
                            input logic [num_threads-1:0][xlen-1:0] exp,
                            input int w, input int r);
        if (got !== exp) begin
            $display("ERR %0t: warp %0d x%0d reads %h, expected %h", $time, w, r, got, exp);
            rd_errs++;
        end
    endtask

    task automatic check_flags(input logic [fflags_bits-1:0] got,
                               input logic [fflags_bits-1:0] exp, input int w);
        if (got !== exp) begin
            $display("ERR %0t: warp %0d flags %b, expected %b", $time, w, got, exp);
            flags_errs++;
        end
    endtask

    task automatic check_count(input logic [cnt_bits-1:0] got,
                               input logic [cnt_bits-1:0] exp, input int w);
        if (got !== exp) begin
            $display("ERR %0t: warp %0d count %0d, expected %0d", $time, w, got, exp);
            count_errs++;
        end
    endtask

    // predicts readies and the effect of the next edge.
    task automatic predict();
        logic       blocked;
        logic [5:0] rdy;
        int         win;
        blocked = 1'b0;
        win     = -1;
        for (int s = 0; s < 5; s++) begin
            rdy[s] = !blocked;
            if (src[s].valid && src[s].wb) begin
                blocked = 1'b1;
            end
        end
        rdy[5] = 1'b1;
        check_ready("alu", alu_ready, rdy[0]);
        check_ready("lsu", lsu_ready, rdy[1]);
        check_ready("csr", csr_ready, rdy[2]);
        check_ready("mul", mul_ready, rdy[3]);
        check_ready("fpu", fpu_ready, rdy[4]);
        check_ready("gpu", gpu_ready, rdy[5]);
        check_flags(flags, flags_m[flags_wid], int'(flags_wid));
        check_count(count, cnt_m[cnt_wid], int'(cnt_wid));
        for (int s = 0; s < 6; s++) begin
            acc_q[s] = src[s].valid && rdy[s];
            if (acc_q[s]) begin
                cnt_m[src[s].wid] = cnt_m[src[s].wid] + 1;
                if (win < 0 && s < 5 && src[s].wb) begin
                    win = s;
                end
            end
        end
        if (flags_clr) begin
            flags_m[flags_wid] = '0;
        end
        if (acc_q[4]) begin
            flags_m[src[4].wid] = flags_m[src[4].wid] | fpu_ff; // set beats clear.
        end
        exp_wb = '0;
        if (win >= 0) begin
            exp_wb.valid = 1'b1;
            exp_wb.wid   = src[win].wid;
            exp_wb.pc    = src[win].pc;
            exp_wb.tmask = src[win].tmask;
            exp_wb.rd    = src[win].rd;
            exp_wb.data  = src[win].data;
            for (int t = 0; t < num_threads; t++) begin
                if (src[win].tmask[t] && src[win].rd != '0) begin
                    regs_m[src[win].wid][src[win].rd][t] = src[win].data[t];
                end
            end
        end
    endtask

    task automatic run_cycle();
        #1;
        predict();
        @(posedge clk);
        #2;
        check_wb(wb_out, exp_wb);
        for (int s = 0; s < 6; s++) begin
            if (acc_q[s]) begin
                src[s].valid = 1'b0;
            end
        end
    endtask

    task automatic gen_traffic();
        logic [31:0] r;
        for (int s = 0; s < 6; s++) begin
            r = rand32();
            if (!src[s].valid && r[0]) begin
                src[s].valid = 1'b1;
                src[s].wid   = r[3:2];
                src[s].rd    = r[8:4];
                src[s].wb    = (s != 5) && (r[11:9] != 3'b000);
                src[s].tmask = r[15:12];
                if (src[s].wb && src[s].tmask == '0) begin
                    src[s].tmask = 4'b1000;
                end
                src[s].pc = rand32();
                for (int t = 0; t < num_threads; t++) begin
                    src[s].data[t] = rand32();
                end
                if (s == 4) begin
                    fpu_ff = r[20:16] & r[25:21]; // sparse flags.
                end
            end
        end
        r = rand32();
        flags_clr = (r[3:0] == 4'h0);
        flags_wid = r[5:4];
        cnt_wid   = r[7:6];
    endtask

    initial begin
        #(total_cycles * 20);
        $display("timeout: the run did not finish within %0d cycles", total_cycles);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int total;
        clk       = 1'b0;
        rst       = 1'b1;
        fpu_ff    = '0;
        rd_en     = 1'b0;
        rd_wid    = '0;
        rd_reg    = '0;
        flags_clr = 1'b0;
        flags_wid = '0;
        cnt_wid   = '0;
        exp_wb    = '0;
        acc_q     = '0;
        for (int s = 0; s < 6; s++) begin
            src[s] = '0;
        end
        // a pending write during reset must not reach wb_out.
        src[0].valid = 1'b1;
        src[0].wb    = 1'b1;
        src[0].tmask = '1;
        for (int w = 0; w < num_warps; w++) begin
            flags_m[w] = '0;
            cnt_m[w]   = '0;
            for (int r = 0; r < num_regs; r++) begin
                regs_m[w][r] = '0;
            end
        end
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        check_wb(wb_out, exp_wb);

        // fill every register so later reads are defined.
        for (int w = 0; w < num_warps; w++) begin
            for (int r = 1; r < num_regs; r++) begin
                src[0]       = '0;
                src[0].valid = 1'b1;
                src[0].wid   = nw_bits'(w);
                src[0].rd    = nr_bits'(r);
                src[0].wb    = 1'b1;
                src[0].tmask = '1;
                src[0].pc    = rand32();
                for (int t = 0; t < num_threads; t++) begin
                    src[0].data[t] = rand32();
                end
                cnt_wid = nw_bits'(w);
                run_cycle();
            end
        end

        repeat (rand_cycles) begin
            gen_traffic();
            run_cycle();
        end

        for (int s = 0; s < 6; s++) begin
            src[s].valid = 1'b0;
        end
        flags_clr = 1'b0;
        repeat (3) run_cycle();

        // one read per cycle with the result one edge later.
        for (int w = 0; w < num_warps; w++) begin
            for (int r = 0; r < num_regs; r++) begin
                rd_en  = 1'b1;
                rd_wid = nw_bits'(w);
                rd_reg = nr_bits'(r);
                @(posedge clk);
                #2;
                check_rd(rd_data, regs_m[w][r], w, r);
            end
        end
        rd_en = 1'b0;

        for (int w = 0; w < num_warps; w++) begin
            flags_wid = nw_bits'(w);
            cnt_wid   = nw_bits'(w);
            #1;
            check_flags(flags, flags_m[w], w);
            check_count(count, cnt_m[w], w);
            @(posedge clk);
            #2;
        end

        total = ready_errs + wb_errs + rd_errs + flags_errs + count_errs;
        $display("errors: ready %0d, wb %0d, regs %0d, flags %0d, count %0d",
                 ready_errs, wb_errs, rd_errs, flags_errs, count_errs);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
logic/wb_pkg.sv
logic/writeback_stage.sv
logic/gpr_file.sv
logic/fflags_accum.sv
logic/retire_counter.sv
logic/writeback_top.sv
test/tb_writeback.sv

// File: Makefile
SIM      := verilator
TOP      := tb_writeback
FILELIST := filelist.f
FLAGS    := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
